//--- alu_top.f
hw/alu_types_pkg.sv
hw/alu_ops_pkg.sv
hw/alu_op_decode.sv
hw/alu_arith.sv
hw/alu_mul_logic.sv
hw/alu_result_stage.sv
hw/alu_top.sv
test/tb_clock_gen.sv
test/alu_top_assertions.sv
test/alu_top_tb.sv

//--- hw/alu_arith.sv
/*
 * ALU arithmetic unit
 * one shared 9 bit adder covers negate, inc, dec, add and the subtracts
 * with operand swap, inversion of the right operand and a selected carry in
 */
`timescale 1ns/1ps
`default_nettype none

module alu_arith (
    input  wire  alu_types_pkg::data_t  a,
    input  wire  alu_types_pkg::data_t  b,
    input  wire  alu_ops_pkg::alu_op_t  op_eff,
    output alu_types_pkg::wide_t        arith_value,  // carry or borrow in bit 8
    output logic                        arith_ovf
);
    import alu_types_pkg::*;
    import alu_ops_pkg::*;

    data_t lhs;         // left adder operand after the swap
    data_t rhs;         // right operand before inversion
    data_t rhs_in;      // right operand as the adder sees it
    logic  sub_en;      // subtract by adding the inverted right operand
    logic  cin_sel;     // carry into bit 0
    logic  carry_kill;  // negate reports no carry at all
    logic  ovf_en;      // only the two operand add and subtract ops overflow
    wide_t sum;
    logic  carry;

    always_comb begin
        lhs        = '0;
        rhs        = '0;
        sub_en     = 1'b0;
        cin_sel    = 1'b0;
        carry_kill = 1'b0;
        ovf_en     = 1'b0;
        case (op_eff)
            OP_NEG_A:     begin rhs = a; sub_en = 1'b1; cin_sel = 1'b1; carry_kill = 1'b1; end
            OP_NEG_B:     begin rhs = b; sub_en = 1'b1; cin_sel = 1'b1; carry_kill = 1'b1; end
            OP_A_PLUS_1:  begin lhs = a; cin_sel = 1'b1; end                // a + 0 + 1
            OP_B_PLUS_1:  begin lhs = b; cin_sel = 1'b1; end
            OP_A_MINUS_1: begin lhs = a; rhs = 8'd1; sub_en = 1'b1; cin_sel = 1'b1; end
            OP_B_MINUS_1: begin lhs = b; rhs = 8'd1; sub_en = 1'b1; cin_sel = 1'b1; end
            OP_A_PLUS_B: begin
                lhs    = a;
                rhs    = b;
                ovf_en = 1'b1;
            end
            OP_A_MINUS_B, OP_A_MINUS_B_SIGNEDMAG: begin
                lhs     = a;
                rhs     = b;
                sub_en  = 1'b1;
                cin_sel = 1'b1;  // two's complement of b
                ovf_en  = 1'b1;
            end
            OP_B_MINUS_A: begin
                lhs     = b;     // swapped operands
                rhs     = a;
                sub_en  = 1'b1;
                cin_sel = 1'b1;
                ovf_en  = 1'b1;
            end
            OP_A_PLUS_B_PLUS_C: begin
                lhs     = a;
                rhs     = b;
                cin_sel = 1'b1;  // the extra 1 rides in on the carry
                ovf_en  = 1'b1;
            end
            OP_A_MINUS_B_MINUS_C: begin
                lhs    = a;
                rhs    = b;
                sub_en = 1'b1;   // a + ~b with no +1 gives a - b - 1
                ovf_en = 1'b1;
            end
            OP_B_MINUS_A_MINUS_C: begin
                lhs    = b;
                rhs    = a;
                sub_en = 1'b1;
                ovf_en = 1'b1;
            end
            default: ;           // not an adder op so the value is never selected
        endcase
    end

    assign rhs_in = sub_en ? ~rhs : rhs;
    assign sum    = wide_t'(lhs) + wide_t'(rhs_in) + wide_t'(cin_sel);

    // the adder carry out is the inverse of the borrow when subtracting
    assign carry = carry_kill ? 1'b0 : (sum[8] ^ sub_en);

    assign arith_value = {carry, sum[7:0]};

    // add overflows on equal signs, subtract on differing signs
    // and in both cases only when the result sign leaves the left sign
    assign arith_ovf = ovf_en
                     & ((lhs[7] == rhs[7]) ^ sub_en)
                     & (sum[7] != lhs[7]);

endmodule : alu_arith

`default_nettype wire

//--- hw/alu_mul_logic.sv
/*
 * ALU multiply and logic unit
 * one 8x8 product feeds both multiply ops, plus and/or, pass a, pass b and zero
 */
`timescale 1ns/1ps
`default_nettype none

module alu_mul_logic (
    input  wire  alu_types_pkg::data_t  a,
    input  wire  alu_types_pkg::data_t  b,
    input  wire  alu_ops_pkg::alu_op_t  op_eff,
    output alu_types_pkg::wide_t        ml_value   // carry in bit 8
);
    import alu_types_pkg::*;
    import alu_ops_pkg::*;

    product_t product;
    logic     hi_nonzero;  // lo byte alone does not hold the product

    assign product    = product_t'(a) * product_t'(b);
    assign hi_nonzero = |product[15:8];

    always_comb begin
        case (op_eff)
            OP_PASS_A:       ml_value = {1'b0, a};
            OP_PASS_B:       ml_value = {1'b0, b};
            OP_A_TIMES_B_LO: ml_value = {hi_nonzero, product[7:0]};
            OP_A_TIMES_B_HI: ml_value = {1'b0, product[15:8]};  // hi byte never carries
            OP_A_AND_B:      ml_value = {1'b0, a & b};
            OP_A_OR_B:       ml_value = {1'b0, a | b};
            default: begin
                // OP_ZERO lands here too, as does any op the decoder routed elsewhere
                ml_value = '0;
            end
        endcase
    end

endmodule : alu_mul_logic

`default_nettype wire

//--- hw/alu_op_decode.sv
/*
 * ALU operation decoder
 * applies the carry remap, picks the function unit for the effective op
 * and flags the signed magnitude compare
 */
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode (
    input  wire  alu_ops_pkg::alu_op_t     alu_op,
    input  wire  logic                     carry_in,   // high means a carry is present
    output alu_ops_pkg::alu_op_t           op_eff,
    output alu_types_pkg::unit_sel_t       unit_sel,
    output logic                           signed_cmp
);
    import alu_ops_pkg::*;
    import alu_types_pkg::*;

    // ops 13 to 15 fall back to 9 to 11 when there is no carry to consume
    assign op_eff = remap_carry_op(alu_op, carry_in);

    // only the signed magnitude subtract compares the operands as signed bytes
    assign signed_cmp = (op_eff == OP_A_MINUS_B_SIGNEDMAG);

    always_comb begin
        case (op_eff)
            OP_NEG_A, OP_NEG_B,
            OP_A_PLUS_1, OP_B_PLUS_1, OP_A_MINUS_1, OP_B_MINUS_1,
            OP_A_PLUS_B, OP_A_MINUS_B, OP_B_MINUS_A, OP_A_MINUS_B_SIGNEDMAG,
            OP_A_PLUS_B_PLUS_C, OP_A_MINUS_B_MINUS_C, OP_B_MINUS_A_MINUS_C: begin
                unit_sel = UNIT_ARITH;  // everything that goes through the adder
            end
            OP_ZERO, OP_PASS_A, OP_PASS_B,
            OP_A_TIMES_B_LO, OP_A_TIMES_B_HI,
            OP_A_AND_B, OP_A_OR_B: begin
                unit_sel = UNIT_MUL_LOGIC;
            end
            default: begin
                // div, mod, shifts, rotates, xor, not and bcd have no hardware
                unit_sel = UNIT_ILLEGAL;
            end
        endcase
    end

endmodule : alu_op_decode

`default_nettype wire

//--- hw/alu_ops_pkg.sv
/*
 * ALU operation set
 * opcode map in the cpu numbering and the rule that folds the
 * carry consuming ops onto their plain forms when no carry is present
 */
`default_nettype none

package alu_ops_pkg;

    // all 32 slots keep a name so that illegal codes stay readable in waves
    typedef enum logic [4:0] {
        OP_ZERO                = 5'd0,
        OP_PASS_A              = 5'd1,
        OP_PASS_B              = 5'd2,
        OP_NEG_A               = 5'd3,
        OP_NEG_B               = 5'd4,
        OP_A_PLUS_1            = 5'd5,
        OP_B_PLUS_1            = 5'd6,
        OP_A_MINUS_1           = 5'd7,
        OP_B_MINUS_1           = 5'd8,
        OP_A_PLUS_B            = 5'd9,
        OP_A_MINUS_B           = 5'd10,
        OP_B_MINUS_A           = 5'd11,
        OP_A_MINUS_B_SIGNEDMAG = 5'd12,  // also switches gt/lt to a signed compare
        OP_A_PLUS_B_PLUS_C     = 5'd13,
        OP_A_MINUS_B_MINUS_C   = 5'd14,
        OP_B_MINUS_A_MINUS_C   = 5'd15,
        OP_A_TIMES_B_LO        = 5'd16,
        OP_A_TIMES_B_HI        = 5'd17,
        OP_A_DIV_B             = 5'd18,  // slots 18 to 24 have no datapath
        OP_A_MOD_B             = 5'd19,
        OP_A_SHL_B             = 5'd20,
        OP_A_SHR_B_L           = 5'd21,
        OP_A_SHR_B_A           = 5'd22,
        OP_A_ROL_B             = 5'd23,
        OP_A_ROR_B             = 5'd24,
        OP_A_AND_B             = 5'd25,
        OP_A_OR_B              = 5'd26,
        OP_A_XOR_B             = 5'd27,  // slots 27 to 31 have no datapath either
        OP_NOT_A               = 5'd28,
        OP_NOT_B               = 5'd29,
        OP_A_PLUS_B_BCD        = 5'd30,
        OP_A_MINUS_B_BCD       = 5'd31
    } alu_op_t;

    // with carry_in low the three carry ops behave exactly like the plain ones
    // so they collapse here and the datapath never sees them without a carry
    function automatic alu_op_t remap_carry_op(alu_op_t op, logic carry_in);
        if (carry_in) begin
            return op;  // carry present so the op keeps its +1 or -1
        end
        case (op)
            OP_A_PLUS_B_PLUS_C:   return OP_A_PLUS_B;
            OP_A_MINUS_B_MINUS_C: return OP_A_MINUS_B;
            OP_B_MINUS_A_MINUS_C: return OP_B_MINUS_A;
            default:              return op;
        endcase
    endfunction

endpackage : alu_ops_pkg

`default_nettype wire

//--- hw/alu_result_stage.sv
/*
 * ALU result stage
 * takes the selected unit value, derives every flag and registers it all
 * so the top level has exactly one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage (
    input  wire  logic                      clk,
    input  wire  logic                      arst_n,
    input  wire  alu_types_pkg::data_t      a,
    input  wire  alu_types_pkg::data_t      b,
    input  wire  alu_types_pkg::unit_sel_t  unit_sel,
    input  wire  logic                      signed_cmp,   // op 12 compares signed
    input  wire  alu_types_pkg::wide_t      arith_value,
    input  wire  alu_types_pkg::wide_t      ml_value,
    input  wire  logic                      arith_ovf,
    output alu_types_pkg::data_t            result,
    output logic                            flag_c,
    output logic                            flag_z,
    output logic                            flag_n,
    output logic                            flag_o,
    output logic                            flag_gt,
    output logic                            flag_lt,
    output logic                            flag_eq,
    output logic                            flag_ne,
    output logic                            op_illegal
);
    import alu_types_pkg::*;

    wide_t sel_value;     // chosen unit value with its carry
    logic  sel_ovf;
    logic  illegal_next;
    logic  z_next;
    logic  gt_next;
    logic  lt_next;

    always_comb begin
        sel_value    = '0;    // illegal ops leave a clear value and carry
        sel_ovf      = 1'b0;
        illegal_next = 1'b0;
        case (unit_sel)
            UNIT_ARITH: begin
                sel_value = arith_value;
                sel_ovf   = arith_ovf;
            end
            UNIT_MUL_LOGIC: sel_value = ml_value;  // multiply and logic never overflow
            default:        illegal_next = 1'b1;
        endcase
    end

    // an illegal op reports no zero flag even though its result byte is 0
    assign z_next = ~illegal_next & (sel_value[7:0] == 8'h00);

    // compare flags follow the operands for every opcode, legal or not
    assign gt_next = signed_cmp ? ($signed(a) > $signed(b)) : (a > b);
    assign lt_next = signed_cmp ? ($signed(a) < $signed(b)) : (a < b);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result     <= '0;
            flag_c     <= 1'b0;
            flag_z     <= 1'b0;
            flag_n     <= 1'b0;
            flag_o     <= 1'b0;
            flag_gt    <= 1'b0;
            flag_lt    <= 1'b0;
            flag_eq    <= 1'b0;   // eq and ne both low only while in reset
            flag_ne    <= 1'b0;
            op_illegal <= 1'b0;
        end else begin
            result     <= sel_value[7:0];
            flag_c     <= sel_value[8];   // borrow for the subtract ops
            flag_z     <= z_next;
            flag_n     <= sel_value[7];
            flag_o     <= sel_ovf;
            flag_gt    <= gt_next;
            flag_lt    <= lt_next;
            flag_eq    <= (a == b);
            flag_ne    <= (a != b);
            op_illegal <= illegal_next;
        end
    end

endmodule : alu_result_stage

`default_nettype wire

//--- hw/alu_top.sv
/*
 * ALU top level
 * decoder and the two combinational units feed a single registered result stage
 */
`timescale 1ns/1ps
`default_nettype none

module alu_top (
    input  wire  logic                  clk,
    input  wire  logic                  arst_n,
    input  wire  alu_types_pkg::data_t  a,
    input  wire  alu_types_pkg::data_t  b,
    input  wire  alu_ops_pkg::alu_op_t  alu_op,
    input  wire  logic                  carry_in,    // active high carry
    output alu_types_pkg::data_t        result,
    output logic                        flag_c,
    output logic                        flag_z,
    output logic                        flag_n,
    output logic                        flag_o,
    output logic                        flag_gt,
    output logic                        flag_lt,
    output logic                        flag_eq,
    output logic                        flag_ne,
    output logic                        op_illegal
);
    import alu_types_pkg::*;
    import alu_ops_pkg::*;

    alu_op_t   op_eff;        // opcode after the carry remap
    unit_sel_t unit_sel;
    logic      signed_cmp;
    wide_t     arith_value;
    logic      arith_ovf;
    wide_t     ml_value;

    alu_op_decode u_decode (
        .alu_op     (alu_op),
        .carry_in   (carry_in),
        .op_eff     (op_eff),
        .unit_sel   (unit_sel),
        .signed_cmp (signed_cmp)
    );

    alu_arith u_arith (
        .a           (a),
        .b           (b),
        .op_eff      (op_eff),
        .arith_value (arith_value),
        .arith_ovf   (arith_ovf)
    );

    alu_mul_logic u_mul_logic (
        .a        (a),
        .b        (b),
        .op_eff   (op_eff),
        .ml_value (ml_value)
    );

    // the only clocked block and the source of the single cycle of latency
    alu_result_stage u_result (
        .clk         (clk),
        .arst_n      (arst_n),
        .a           (a),
        .b           (b),
        .unit_sel    (unit_sel),
        .signed_cmp  (signed_cmp),
        .arith_value (arith_value),
        .ml_value    (ml_value),
        .arith_ovf   (arith_ovf),
        .result      (result),
        .flag_c      (flag_c),
        .flag_z      (flag_z),
        .flag_n      (flag_n),
        .flag_o      (flag_o),
        .flag_gt     (flag_gt),
        .flag_lt     (flag_lt),
        .flag_eq     (flag_eq),
        .flag_ne     (flag_ne),
        .op_illegal  (op_illegal)
    );

endmodule : alu_top

`default_nettype wire

//--- hw/alu_types_pkg.sv
/*
 * ALU datapath types
 * operand and result widths, the wide result that carries the carry bit,
 * the full multiplier product and the function unit select
 */
`default_nettype none

package alu_types_pkg;

    localparam int DATA_W = 8;            // operand and result byte
    localparam int WIDE_W = DATA_W + 1;   // byte plus carry or borrow on top
    localparam int PROD_W = 2 * DATA_W;   // unsigned multiplier product

    // one operand or one result byte
    typedef logic [DATA_W-1:0] data_t;

    // result byte with the carry out or borrow in its msb
    typedef logic [WIDE_W-1:0] wide_t;

    // full product of two bytes, split into lo and hi by the multiply ops
    typedef logic [PROD_W-1:0] product_t;

    // which function unit the result stage takes its value from
    // an illegal opcode selects no unit and forces a clear result
    typedef enum logic [1:0] {
        UNIT_ARITH     = 2'd0,  // adder based ops 3 to 15
        UNIT_MUL_LOGIC = 2'd1,  // multiply, and/or, pass and zero
        UNIT_ILLEGAL   = 2'd2   // opcode slot without an implementation
    } unit_sel_t;

endpackage : alu_types_pkg

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the ALU testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=alu_top_sim
LOG=sim.log

verilator --binary --timing --assert --top-module alu_top_tb \
    -f alu_top.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0

//--- test/alu_stim.txt
# beh op a b cin result flags illegal, all hex except beh (decimal) and flags/illegal (binary)
# flags bit order c z n o gt lt eq ne, beh 2 add_sub 3 carry_remap 4 mul_logic 5 compare 6 illegal
2 09 7f 01 0 80 00111001 0
2 0a 00 01 0 ff 10100101 0
2 0b 10 30 0 20 00000101 0
2 09 ff 01 0 00 11001001 0
2 0a 80 01 0 7f 00011001 0
2 03 05 05 0 fb 00100010 0
2 07 00 00 0 ff 10100010 0
2 06 00 ff 0 00 11000101 0
3 0d 20 05 0 25 00001001 0
3 0d 20 05 1 26 00001001 0
3 0e 20 05 0 1b 00001001 0
3 0e 20 05 1 1a 00001001 0
3 0f 20 05 0 e5 10101001 0
3 0f 20 05 1 e4 10101001 0
3 0d 7f 00 1 80 00111001 0
4 10 10 10 0 00 11000010 0
4 11 10 10 0 01 00000010 0
4 10 0f 11 0 ff 00100101 0
4 11 ff ff 0 fe 00100010 0
4 19 f0 3c 0 30 00001001 0
4 1a 0f 30 0 3f 00000101 0
4 19 0f f0 0 00 01000101 0
5 0a fe 03 0 fb 00101001 0
5 0c fe 03 0 fb 00100101 0
5 0c 05 05 0 00 01000010 0
5 01 42 42 0 42 00000010 0
5 02 81 7f 0 7f 00001001 0
6 12 12 34 0 00 00000101 1
6 1b 34 12 0 00 00001001 1
6 00 34 12 0 00 01001001 0
6 1f 00 00 1 00 00000010 1
6 09 01 02 1 03 00000101 0

//--- test/alu_top_assertions.sv
/*
 * ALU result stage checks
 * bound into alu_result_stage, watches the registered outputs on every edge
 */
`timescale 1ns/1ps
`default_nettype none

module alu_top_assertions (
    input wire logic                  clk,
    input wire logic                  arst_n,
    input wire alu_types_pkg::data_t  result,
    input wire logic                  flag_c,
    input wire logic                  flag_z,
    input wire logic                  flag_n,
    input wire logic                  flag_o,
    input wire logic                  flag_gt,
    input wire logic                  flag_lt,
    input wire logic                  flag_eq,
    input wire logic                  flag_ne,
    input wire logic                  op_illegal
);
    logic outputs_live;   // eq and ne are both low until the first edge after reset

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outputs_live <= 1'b0;
        end else begin
            outputs_live <= 1'b1;
        end
    end

    illegal_clears_result: assert property (@(posedge clk) disable iff (!arst_n)
        op_illegal |-> (result == '0 && !flag_c && !flag_z && !flag_n && !flag_o))
        else $error("illegal op left a nonzero result or a set c, z, n or o flag");

    eq_ne_opposite: assert property (@(posedge clk) disable iff (!arst_n)
        outputs_live |-> (flag_eq != flag_ne))
        else $error("flag_eq and flag_ne hold the same value");

    gt_lt_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(flag_gt && flag_lt))
        else $error("flag_gt and flag_lt are both set");

endmodule : alu_top_assertions

bind alu_result_stage alu_top_assertions u_assertions (.*);

`default_nettype wire

//--- test/alu_top_tb.sv
/*
 * ALU testbench
 * plays the stimulus file and a few random and/or vectors through alu_top
 * and checks every registered output one rising edge after it was driven
 */
`timescale 1ns/1ps
`default_nettype none

module alu_top_tb;
    import alu_types_pkg::*;
    import alu_ops_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int RAND_VECTORS   = 6;

    logic       clk;
    logic       arst_n;
    data_t      a;
    data_t      b;
    alu_op_t    alu_op;
    logic       carry_in;
    data_t      result;
    logic       flag_c;
    logic       flag_z;
    logic       flag_n;
    logic       flag_o;
    logic       flag_gt;
    logic       flag_lt;
    logic       flag_eq;
    logic       flag_ne;
    logic       op_illegal;
    logic [7:0] flags_act;    // same bit order as the flags column of the file

    // one entry per vector, from the file first and then the random set
    int         beh_q[$];
    logic [4:0] op_q[$];
    data_t      a_q[$];
    data_t      b_q[$];
    logic       cin_q[$];
    data_t      res_q[$];
    logic [7:0] flags_q[$];   // c z n o gt lt eq ne
    logic       ill_q[$];

    integer seed        = 32'h83363944;
    int     cycle_count = 0;
    int     cycle_limit = RESET_CYCLES + TIMEOUT_MARGIN;
    int     fail_count  = 0;

    assign flags_act = {flag_c, flag_z, flag_n, flag_o, flag_gt, flag_lt, flag_eq, flag_ne};

    tb_clock_gen u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    alu_top uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .a          (a),
        .b          (b),
        .alu_op     (alu_op),
        .carry_in   (carry_in),
        .result     (result),
        .flag_c     (flag_c),
        .flag_z     (flag_z),
        .flag_n     (flag_n),
        .flag_o     (flag_o),
        .flag_gt    (flag_gt),
        .flag_lt    (flag_lt),
        .flag_eq    (flag_eq),
        .flag_ne    (flag_ne),
        .op_illegal (op_illegal)
    );

    function automatic string behavior_name(int beh);
        case (beh)
            1:       return "reset";
            2:       return "add_sub";
            3:       return "carry_remap";
            4:       return "mul_logic";
            5:       return "compare";
            6:       return "illegal_op";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input string test_name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        fail_count++;
        $display("[ERROR] %s %s expected 0x%0h actual 0x%0h", test_name, field, expected, actual);
        $display("TB FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic report_problem(input string what);
        fail_count++;
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopping on a testbench problem");
    endtask

    task automatic load_vectors();
        int          fd;
        int          f_beh;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_cin;
        logic [31:0] f_res;
        logic [31:0] f_flags;
        logic [31:0] f_ill;
        string       line;
        fd = $fopen("test/alu_stim.txt", "r");
        if (fd == 0) begin
            report_problem("could not open the stimulus file test/alu_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                // comment lines and blank lines never parse as eight fields
                if ($fgets(line, fd) > 0 &&
                    $sscanf(line, "%d %h %h %h %h %h %b %b", f_beh, f_op, f_a, f_b,
                            f_cin, f_res, f_flags, f_ill) == 8) begin
                    beh_q.push_back(f_beh);
                    op_q.push_back(f_op[4:0]);
                    a_q.push_back(f_a[7:0]);
                    b_q.push_back(f_b[7:0]);
                    cin_q.push_back(f_cin[0]);
                    res_q.push_back(f_res[7:0]);
                    flags_q.push_back(f_flags[7:0]);
                    ill_q.push_back(f_ill[0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic add_random_vectors();
        logic [31:0] rnd;
        data_t       ra;
        data_t       rb;
        data_t       res;
        logic        use_or;
        for (int i = 0; i < RAND_VECTORS; i++) begin
            rnd    = $random(seed);
            ra     = rnd[7:0];
            rb     = rnd[15:8];
            use_or = rnd[16];
            res    = use_or ? (ra | rb) : (ra & rb);   // op 26 or op 25
            beh_q.push_back(4);
            op_q.push_back(use_or ? 5'd26 : 5'd25);
            a_q.push_back(ra);
            b_q.push_back(rb);
            cin_q.push_back(rnd[17]);                // carry_in has no effect on and/or
            res_q.push_back(res);
            // logic ops never carry or overflow, compares are unsigned
            flags_q.push_back({1'b0, res == 8'h00, res[7], 1'b0,
                               ra > rb, ra < rb, ra == rb, ra != rb});
            ill_q.push_back(1'b0);
        end
    endtask

    task automatic drive_vector(int i);
        a        = a_q[i];
        b        = b_q[i];
        alu_op   = alu_op_t'(op_q[i]);
        carry_in = cin_q[i];
    endtask

    task automatic check_vector(int i);
        string name;
        name = $sformatf("%s vector %0d", behavior_name(beh_q[i]), i);
        assert (result == res_q[i])
            else report_mismatch(name, "result", 32'(res_q[i]), 32'(result));
        assert (flags_act == flags_q[i])
            else report_mismatch(name, "flags czno_gtlteqne", 32'(flags_q[i]), 32'(flags_act));
        assert (op_illegal == ill_q[i])
            else report_mismatch(name, "op_illegal", 32'(ill_q[i]), 32'(op_illegal));
    endtask

    task automatic check_cleared(string name);
        assert ({result, flags_act, op_illegal} == 17'd0)
            else report_mismatch(name, "all outputs", 32'd0,
                                 32'({result, flags_act, op_illegal}));
    endtask

    // hard stop in case the DUT or the testbench stalls
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout, the run went past its limit of %0d clock cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        a        = '0;
        b        = '0;
        alu_op   = OP_ZERO;
        carry_in = 1'b0;
        load_vectors();
        add_random_vectors();
        cycle_limit = RESET_CYCLES + beh_q.size() + TIMEOUT_MARGIN;

        // the last negedge falls after the release but before any edge loads data
        #2;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_cleared(arst_n ? "reset release" : "reset");
        end
        assert (arst_n === 1'b1)
            else report_problem("reset was still asserted after 8 clock cycles");

        @(posedge clk);
        #1;
        drive_vector(0);
        for (int i = 0; i < beh_q.size(); i++) begin
            @(posedge clk);
            #1;
            check_vector(i);                      // result of the vector driven last cycle
            if (i + 1 < beh_q.size()) begin
                drive_vector(i + 1);
            end
        end

        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : alu_top_tb

`default_nettype wire

//--- test/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 10 ns clock, asynchronous reset held low for the first 8 rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    localparam int HALF_PERIOD  = 5;   // ns, gives the 10 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release lands 1 ns after the last reset edge, clear of the clock
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire
